/* common/rom_pkg.sv */
package rom_pkg;

    // Full ROM byte address width of the download port
    localparam int AW = 22;

    typedef logic [AW-1:0] rom_addr_t;  // Byte address
    typedef logic [AW-2:0] word_addr_t; // 16-bit word address

    // Masked word write towards the store
    typedef struct packed {
        word_addr_t  addr;
        logic [15:0] data;  // High byte is the odd address
        logic [1:0]  mask;  // 1 means that byte is written
    } wr_req_t;

    // Game read as it travels to the store
    typedef struct packed {
        word_addr_t addr;   // Even word of the two-word fetch
        logic [1:0] sel;    // Low byte-address bits, pick the byte on return
    } rd_req_t;

    // Two consecutive words, or the same bits seen as four bytes.
    // bytes[0] is the even byte of the word at addr.
    typedef union packed {
        logic [1:0][15:0] words;  // {word at addr+1, word at addr}
        logic [3:0][7:0]  bytes;  // Indexed by byte address [1:0]
    } fetch_u;

endpackage

/* hw/prog_loader.sv */
`timescale 1ns/10ps

module prog_loader(
    input  logic               clk,
    input  logic               reset,
    input  rom_pkg::rom_addr_t ioctl_addr,
    input  logic [7:0]         ioctl_data,
    input  logic               ioctl_wr,
    input  logic               downloading,
    output rom_pkg::wr_req_t   wr_req,
    output logic               wr_valid,
    input  logic               wr_grant
);
    import rom_pkg::*;

    word_addr_t  in_addr;
    logic [1:0]  in_mask;
    logic [15:0] merge_data;
    logic        same_word;
    logic        merge;
    logic        flush;
    logic        emit;
    logic        dl_last;
    logic        dl_fall;

    // Partly filled word
    logic        hold_valid;
    word_addr_t  hold_addr;
    logic [15:0] hold_data;
    logic [1:0]  hold_mask;

    assign in_addr   = ioctl_addr[AW-1:1];
    assign in_mask   = ioctl_addr[0] ? 2'b10 : 2'b01;
    assign same_word = hold_valid && (hold_addr == in_addr);
    assign dl_fall   = dl_last && !downloading;

    // Incoming byte dropped into its half of the held word
    assign merge_data = in_mask[1] ? {ioctl_data, hold_data[7:0]}
                                   : {hold_data[15:8], ioctl_data};

    assign merge = ioctl_wr && same_word && ((hold_mask | in_mask) == 2'b11);
    assign flush = hold_valid && ((ioctl_wr && !same_word) || (!ioctl_wr && dl_fall));
    assign emit  = merge || flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            hold_valid <= 1'b0;
            wr_valid   <= 1'b0;
            dl_last    <= 1'b0;
        end else begin
            dl_last <= downloading;
            if (emit) begin
                wr_valid <= 1'b1;
            end else if (wr_grant) begin
                wr_valid <= 1'b0;
            end
            if (ioctl_wr) begin
                hold_valid <= !merge;   // A full word leaves nothing behind
            end else if (dl_fall) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            hold_addr <= in_addr;
            hold_data <= merge_data;
            hold_mask <= in_mask;
        end
        if (emit) begin
            wr_req.addr <= hold_addr;
            wr_req.data <= merge ? merge_data : hold_data;
            wr_req.mask <= merge ? 2'b11 : hold_mask;   // Lone byte keeps its own bit
        end
    end

    // Arbiter must take each write before the next download byte
    a_no_overrun: assert property (@(posedge clk) disable iff (reset)
        ioctl_wr |-> (!wr_valid || wr_grant))
        else $error("prog_loader: byte arrived with a write still pending");

endmodule

/* hw/rom_reader.sv */
`timescale 1ns/10ps

module rom_reader #(
    parameter int READ_DEPTH = 4    // Power of two, at least 2
)(
    input  logic               clk,
    input  logic               reset,
    input  rom_pkg::rom_addr_t rom_addr,
    input  logic               rom_req,
    output logic [7:0]         rom_data,
    output logic               rom_ok,
    output logic               rom_credit,
    output rom_pkg::rd_req_t   rd_req,
    output logic               rd_valid,
    input  logic               rd_grant,
    input  rom_pkg::fetch_u    fetch,
    input  logic               fetch_ok
);
    import rom_pkg::*;

    localparam int PW = $clog2(READ_DEPTH);

    rd_req_t     queue [READ_DEPTH];
    rd_req_t     new_req;
    rd_req_t     ret_req;

    // One extra bit on each pointer tells full from empty
    logic [PW:0] wr_ptr;
    logic [PW:0] iss_ptr;
    logic [PW:0] ret_ptr;
    logic [PW:0] used;
    logic        full;

    // Fetch always starts on the even word so the byte view covers [1:0]
    assign new_req.addr = {rom_addr[AW-1:2], 1'b0};
    assign new_req.sel  = rom_addr[1:0];

    assign used = wr_ptr - ret_ptr;
    assign full = used == (PW+1)'(READ_DEPTH);

    // Oldest entry not yet sent to the store
    assign rd_valid = wr_ptr != iss_ptr;
    assign rd_req   = queue[iss_ptr[PW-1:0]];

    assign ret_req = queue[ret_ptr[PW-1:0]];  // Oldest in flight

    always_ff @(posedge clk) begin
        if (rom_req) begin
            queue[wr_ptr[PW-1:0]] <= new_req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            iss_ptr    <= '0;
            ret_ptr    <= '0;
            rom_ok     <= 1'b0;
            rom_credit <= 1'b0;
        end else begin
            if (rom_req) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_grant) begin
                iss_ptr <= iss_ptr + 1'b1;
            end
            if (fetch_ok) begin
                ret_ptr <= ret_ptr + 1'b1;
            end
            rom_ok     <= fetch_ok;
            rom_credit <= fetch_ok;   // Slot is free again
        end
    end

    // Byte picked from the returned word pair
    always_ff @(posedge clk) begin
        if (fetch_ok) begin
            rom_data <= fetch.bytes[ret_req.sel];
        end
    end

    // Credits bound the queue, so a full queue means a credit was misused
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        rom_req |-> !full)
        else $error("rom_reader: request without a credit");

    // The store only answers reads that were granted
    a_fetch_issued: assert property (@(posedge clk) disable iff (reset)
        fetch_ok |-> (iss_ptr != ret_ptr))
        else $error("rom_reader: fetch returned with nothing in flight");

endmodule

/* hw/rom_arbiter.sv */
`timescale 1ns/10ps

module rom_arbiter(
    input  rom_pkg::wr_req_t    wr_req,
    input  logic                wr_valid,
    output logic                wr_grant,
    input  rom_pkg::rd_req_t    rd_req,
    input  logic                rd_valid,
    output logic                rd_grant,
    output logic                mem_we,
    output rom_pkg::wr_req_t    mem_wr,
    output logic                mem_re,
    output rom_pkg::word_addr_t mem_addr
);

    // Fixed priority, the download never waits.
    // A read stays queued in the reader while a write holds the port.
    always_comb begin
        wr_grant = wr_valid;
        rd_grant = rd_valid && !wr_valid;
    end

    // Store command
    always_comb begin
        mem_we   = wr_grant;
        mem_wr   = wr_req;
        mem_re   = rd_grant;
        mem_addr = rd_req.addr;     // Read address only
    end

endmodule

/* hw/rom_store.sv */
`timescale 1ns/10ps

module rom_store #(
    parameter int AW = 22   // Byte address width actually backed by memory
)(
    input  logic                clk,
    input  logic                reset,
    input  logic                mem_we,
    input  rom_pkg::wr_req_t    mem_wr,
    input  logic                mem_re,
    input  rom_pkg::word_addr_t mem_addr,
    output rom_pkg::fetch_u     fetch,
    output logic                fetch_ok
);

    localparam int WAW   = AW - 1;
    localparam int WORDS = 1 << WAW;

    logic [15:0]    mem [WORDS];
    logic [WAW-1:0] wr_idx;
    logic [WAW-1:0] lo_idx;
    logic [WAW-1:0] hi_idx;
    logic [15:0]    lo_q;
    logic [15:0]    hi_q;
    logic           rd_v;

    assign wr_idx = mem_wr.addr[WAW-1:0];
    assign lo_idx = mem_addr[WAW-1:0];
    assign hi_idx = lo_idx + 1'b1;    // Wraps at the top of memory

    // Byte-masked write, stage one of the read
    always_ff @(posedge clk) begin
        if (mem_we) begin
            if (mem_wr.mask[0]) mem[wr_idx][7:0]  <= mem_wr.data[7:0];
            if (mem_wr.mask[1]) mem[wr_idx][15:8] <= mem_wr.data[15:8];
        end
        if (mem_re) begin
            lo_q <= mem[lo_idx];
            hi_q <= mem[hi_idx];
        end
        if (rd_v) begin
            fetch.words <= {hi_q, lo_q};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_v     <= 1'b0;
            fetch_ok <= 1'b0;
        end else begin
            rd_v     <= mem_re;
            fetch_ok <= rd_v;   // Two cycles after the grant
        end
    end

    // Loader never sends an empty write
    a_mask_set: assert property (@(posedge clk) disable iff (reset)
        mem_we |-> (mem_wr.mask != 2'b00))
        else $error("rom_store: write with an empty byte mask");

endmodule

/* hw/rom_sys.sv */
`timescale 1ns/10ps

module rom_sys #(
    parameter int AW         = rom_pkg::AW,
    parameter int READ_DEPTH = 4
)(
    input  logic               clk,
    input  logic               reset,
    // Download
    input  rom_pkg::rom_addr_t ioctl_addr,
    input  logic [7:0]         ioctl_data,
    input  logic               ioctl_wr,
    input  logic               downloading,
    // Game reads
    input  rom_pkg::rom_addr_t rom_addr,
    input  logic               rom_req,
    output logic [7:0]         rom_data,
    output logic               rom_ok,
    output logic               rom_credit
);
    import rom_pkg::*;

    wr_req_t    wr_req;
    logic       wr_valid;
    logic       wr_grant;
    rd_req_t    rd_req;
    logic       rd_valid;
    logic       rd_grant;
    logic       mem_we;
    wr_req_t    mem_wr;
    logic       mem_re;
    word_addr_t mem_addr;
    fetch_u     fetch;
    logic       fetch_ok;

    prog_loader u_loader(
        .clk         ( clk         ),
        .reset       ( reset       ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .downloading ( downloading ),
        .wr_req      ( wr_req      ),
        .wr_valid    ( wr_valid    ),
        .wr_grant    ( wr_grant    )
    );

    rom_reader #(.READ_DEPTH(READ_DEPTH)) u_reader(
        .clk        ( clk        ),
        .reset      ( reset      ),
        .rom_addr   ( rom_addr   ),
        .rom_req    ( rom_req    ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .rom_credit ( rom_credit ),
        .rd_req     ( rd_req     ),
        .rd_valid   ( rd_valid   ),
        .rd_grant   ( rd_grant   ),
        .fetch      ( fetch      ),
        .fetch_ok   ( fetch_ok   )
    );

    rom_arbiter u_arbiter(
        .wr_req   ( wr_req   ),
        .wr_valid ( wr_valid ),
        .wr_grant ( wr_grant ),
        .rd_req   ( rd_req   ),
        .rd_valid ( rd_valid ),
        .rd_grant ( rd_grant ),
        .mem_we   ( mem_we   ),
        .mem_wr   ( mem_wr   ),
        .mem_re   ( mem_re   ),
        .mem_addr ( mem_addr )
    );

    rom_store #(.AW(AW)) u_store(
        .clk      ( clk      ),
        .reset    ( reset    ),
        .mem_we   ( mem_we   ),
        .mem_wr   ( mem_wr   ),
        .mem_re   ( mem_re   ),
        .mem_addr ( mem_addr ),
        .fetch    ( fetch    ),
        .fetch_ok ( fetch_ok )
    );

endmodule

/* sim/rom_checker.sv */
`timescale 1ns/10ps

module rom_checker #(
    parameter int AW         = 12,
    parameter int READ_DEPTH = 4
)(
    input  logic               clk,
    input  logic               reset,
    input  rom_pkg::rom_addr_t ioctl_addr,
    input  logic [7:0]         ioctl_data,
    input  logic               ioctl_wr,
    input  logic               downloading,
    input  rom_pkg::rom_addr_t rom_addr,
    input  logic               rom_req,
    input  logic [7:0]         rom_data,
    input  logic               rom_ok,
    input  logic               rom_credit,
    output int                 data_errors,
    output int                 proto_errors,
    output int                 outstanding
);
    localparam int READ_LATENCY = 4;    // Request to rom_ok with the port idle
    localparam int QUIET        = 10;   // Cycles after download activity until writes are gone

    logic [7:0] model [1 << AW];
    logic [7:0] exp_q [$];
    int         addr_q [$];
    int         cyc_q [$];
    int         cycle;
    int         last_dl;
    int         req_cyc;
    int         addr;
    logic [7:0] exp;

    // Sampled mid-cycle, where inputs and registered outputs are settled
    always @(negedge clk) begin
        if (reset) begin
            exp_q.delete();
            addr_q.delete();
            cyc_q.delete();
            cycle        = 0;
            last_dl      = 0;
            data_errors  = 0;
            proto_errors = 0;
        end else begin
            cycle++;
            if (downloading || ioctl_wr) last_dl = cycle;
            if (ioctl_wr) model[ioctl_addr[AW-1:0]] = ioctl_data;
            if (rom_ok != rom_credit) begin
                $display("At %0t rom_credit did not follow rom_ok, a credit was lost", $time);
                proto_errors++;
            end
            // Slot retiring this cycle cannot be reused yet
            if (rom_req && exp_q.size() >= READ_DEPTH) begin
                $display("At %0t a read was requested with %0d already outstanding",
                         $time, exp_q.size());
                proto_errors++;
            end
            if (rom_ok) begin
                if (exp_q.size() == 0) begin
                    $display("At %0t rom_ok came with no read outstanding", $time);
                    proto_errors++;
                end else begin
                    exp     = exp_q.pop_front();
                    addr    = addr_q.pop_front();
                    req_cyc = cyc_q.pop_front();
                    if (rom_data !== exp) begin
                        $display("Error: %0t rom_data expected %02h actual %02h (byte %03h)",
                                 $time, exp, rom_data, addr);
                        data_errors++;
                    end
                    if (cycle - req_cyc < READ_LATENCY) begin
                        $display("At %0t read of byte %03h returned after only %0d cycles",
                                 $time, addr, cycle - req_cyc);
                        proto_errors++;
                    end else if (req_cyc > last_dl + QUIET && cycle - req_cyc != READ_LATENCY) begin
                        $display("At %0t idle read of byte %03h took %0d cycles instead of %0d",
                                 $time, addr, cycle - req_cyc, READ_LATENCY);
                        proto_errors++;
                    end
                end
            end
            if (rom_req) begin
                exp_q.push_back(model[rom_addr[AW-1:0]]);
                addr_q.push_back(int'(rom_addr[AW-1:0]));
                cyc_q.push_back(cycle);
            end
        end
        outstanding = exp_q.size();
    end

endmodule

/* sim/rom_sys_tb.sv */
`timescale 1ns/10ps

module rom_sys_tb;
    localparam int AW          = 12;
    localparam int READ_DEPTH  = 4;
    localparam int ROM_BYTES   = 1 << AW;
    localparam int LONE_WORDS  = 16;
    localparam int LONE_BLOCK  = ROM_BYTES / 2 / LONE_WORDS;
    localparam int PART_BYTES  = 256;
    localparam int BURST_READS = 400;
    localparam int SIDE_READS  = 200;   // Run alongside the second download
    localparam int BYTES       = ROM_BYTES + LONE_WORDS + PART_BYTES;
    localparam int READS       = BURST_READS + 2 * LONE_WORDS + SIDE_READS;
    localparam int LIMIT       = BYTES * 4 + READS * 8 + 200;

    logic               clk;
    logic               reset;
    rom_pkg::rom_addr_t ioctl_addr;
    logic [7:0]         ioctl_data;
    logic               ioctl_wr;
    logic               downloading;
    rom_pkg::rom_addr_t rom_addr;
    logic               rom_req;
    logic [7:0]         rom_data;
    logic               rom_ok;
    logic               rom_credit;
    int                 data_errors;
    int                 proto_errors;
    int                 outstanding;
    int                 end_errors;
    int                 credits;
    int                 order [ROM_BYTES/2];
    int                 side_addr [SIDE_READS];
    int                 side_gap [SIDE_READS];

    rom_sys #(.AW(AW), .READ_DEPTH(READ_DEPTH)) dut(
        .clk(clk), .reset(reset),
        .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
        .ioctl_wr(ioctl_wr), .downloading(downloading),
        .rom_addr(rom_addr), .rom_req(rom_req), .rom_data(rom_data),
        .rom_ok(rom_ok), .rom_credit(rom_credit)
    );

    rom_checker #(.AW(AW), .READ_DEPTH(READ_DEPTH)) u_checker(
        .clk(clk), .reset(reset),
        .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
        .ioctl_wr(ioctl_wr), .downloading(downloading),
        .rom_addr(rom_addr), .rom_req(rom_req), .rom_data(rom_data),
        .rom_ok(rom_ok), .rom_credit(rom_credit),
        .data_errors(data_errors), .proto_errors(proto_errors), .outstanding(outstanding)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Returned credits are seen mid-cycle and spent after the next edge
    always @(negedge clk) begin
        if (reset) credits = READ_DEPTH;
        else if (rom_credit) credits++;
    end

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic send_byte(input int addr);
        ioctl_addr = rom_pkg::rom_addr_t'(addr);
        ioctl_data = 8'($urandom);
        ioctl_wr   = 1'b1;
        step(1);
        ioctl_wr   = 1'b0;
        step(3);    // One byte every 4 cycles
    endtask

    task automatic begin_download();
        downloading = 1'b1;
        step(2);
    endtask

    task automatic end_download();
        downloading = 1'b0;
        step(20);   // Last lone byte flushes here
    endtask

    task automatic issue_read(input int addr);
        while (credits == 0) step(1);
        rom_addr = rom_pkg::rom_addr_t'(addr);
        rom_req  = 1'b1;
        credits--;
        step(1);
        rom_req  = 1'b0;
    endtask

    task automatic print_summary();
        $display("rom_sys_tb: %0d errors (%0d data, %0d protocol, %0d end of run)",
                 data_errors + proto_errors + end_errors, data_errors, proto_errors, end_errors);
    endtask

    initial begin
        int i;
        int j;
        int tmp;
        int first;
        int gap;
        int word;
        reset       = 1'b1;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        downloading = 1'b0;
        rom_addr    = '0;
        rom_req     = 1'b0;
        end_errors  = 0;
        void'($urandom(28));
        step(10);
        reset = 1'b0;
        step(5);

        // Whole ROM, words shuffled, the two bytes of a word in random order
        for (i = 0; i < ROM_BYTES / 2; i++) order[i] = i;
        for (i = ROM_BYTES / 2 - 1; i > 0; i--) begin
            j        = $urandom % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        begin_download();
        for (i = 0; i < ROM_BYTES / 2; i++) begin
            first = $urandom % 2;
            send_byte(2 * order[i] + first);
            send_byte(2 * order[i] + 1 - first);
        end
        end_download();

        // First half back to back as credits allow, then with gaps
        for (i = 0; i < BURST_READS; i++) begin
            issue_read($urandom % ROM_BYTES);
            if (i >= BURST_READS / 2) begin
                gap = $urandom % 4;
                if (gap != 0) step(gap);
            end
        end

        // Lone bytes in separate blocks, then both bytes of each word
        begin_download();
        for (i = 0; i < LONE_WORDS; i++) begin
            order[i] = i * LONE_BLOCK + $urandom % LONE_BLOCK;
            first    = $urandom % 2;
            send_byte(2 * order[i] + first);
        end
        end_download();
        for (i = 0; i < LONE_WORDS; i++) begin
            issue_read(2 * order[i]);
            issue_read(2 * order[i] + 1);
        end

        // Reads of the high half drawn up front, so only the download draws in the fork
        for (i = 0; i < SIDE_READS; i++) begin
            side_addr[i] = ROM_BYTES / 2 + $urandom % (ROM_BYTES / 2);
            side_gap[i]  = $urandom % 4;
        end
        fork
            begin
                begin_download();
                for (int k = 0; k < PART_BYTES; k++) begin
                    word = $urandom % (ROM_BYTES / 2);  // Low half only
                    send_byte(word);
                end
                end_download();
            end
            begin
                for (int k = 0; k < SIDE_READS; k++) begin
                    issue_read(side_addr[k]);
                    if (side_gap[k] != 0) step(side_gap[k]);
                end
            end
        join

        while (credits != READ_DEPTH) step(1);
        step(4);
        if (outstanding != 0) begin
            $display("%0d reads still outstanding at the end of the run", outstanding);
            end_errors++;
        end
        print_summary();
        if (data_errors + proto_errors + end_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the byte and read counts
    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("Timeout: run still going after %0d cycles", LIMIT);
        print_summary();
        $display("Test failed");
        $finish;
    end

endmodule

/* all.f */
common/rom_pkg.sv
hw/prog_loader.sv
hw/rom_reader.sv
hw/rom_arbiter.sv
hw/rom_store.sv
hw/rom_sys.sv
sim/rom_checker.sv
sim/rom_sys_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the ROM path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f \
    --top-module rom_sys_tb \
    -o rom_sys_sim

./obj_dir/rom_sys_sim | tee sim.log

if grep -qx "Test passed" sim.log; then
    echo "run.sh: simulation passed"
    exit 0
else
    echo "run.sh: simulation failed"
    exit 1
fi
